// ==== design/qm_free_list.sv ====
/*
 * Free buffer list.
 * Circular FIFO of buffer indices, filled with every index after reset.
 */
`timescale 1ns/1ps

module qm_free_list (
	input  logic clk,
	input  logic rst_n,
	input  logic pop,
	input  logic push,
	input  qm_pkg::buf_t push_buf,
	output qm_pkg::buf_t head_buf,
	output qm_pkg::cnt_t free_count,
	output logic ready
);

	import qm_pkg::*;

	buf_t rd_ptr;
	buf_t wr_ptr;
	buf_t rd_addr;
	logic ram_wr;
	buf_t ram_wdata;

	// While filling, each cycle writes the index equal to its own slot.
	assign ram_wr = push | ~ready;
	assign ram_wdata = ready ? push_buf : wr_ptr;

	// Read ahead so head_buf follows a pop in the next cycle.
	assign rd_addr = pop ? rd_ptr + buf_t'(1) : rd_ptr;

	qm_ram #(
		.T(buf_t),
		.DEPTH(NUM_BUFS)
	) ram_i (
		.clk(clk),
		.wr(ram_wr),
		.waddr(wr_ptr),
		.wdata(ram_wdata),
		.raddr(rd_addr),
		.rdata(head_buf)
	);

	// ------------------------------------------------------------
	// Pointers and count
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			free_count <= '0;
			ready <= 1'b0;
		end else begin
			if (pop) begin
				rd_ptr <= rd_addr;
			end
			if (ram_wr) begin
				wr_ptr <= wr_ptr + buf_t'(1);
			end
			free_count <= free_count + cnt_t'(ram_wr) - cnt_t'(pop);
			// Last index written, pointer wraps back to 0.
			if (!ready && wr_ptr == buf_t'(NUM_BUFS - 1)) begin
				ready <= 1'b1;
			end
		end
	end

endmodule

// ==== design/qm_link_engine.sv ====
/*
 * Linked list engine.
 * Clears the depth table, then runs one enqueue or dequeue at a time
 * over the head, tail, link, depth and descriptor tables.
 */
`timescale 1ns/1ps

module qm_link_engine (
	input  logic clk,
	input  logic rst_n,
	input  logic enq_req,
	input  qm_pkg::qid_t enq_qid,
	input  qm_pkg::pkt_desc_t enq_desc,
	output logic enq_ack,
	output logic enq_ok,
	output logic enq_to_empty,
	input  logic deq_req,
	input  qm_pkg::qid_t deq_qid,
	output logic deq_ack,
	output logic deq_ok,
	output qm_pkg::pkt_desc_t deq_desc,
	input  logic free_ready,
	input  qm_pkg::buf_t free_head,
	input  qm_pkg::cnt_t free_count,
	output logic free_pop,
	output logic free_push,
	output qm_pkg::buf_t free_push_buf,
	output logic depth_wr,
	output qm_pkg::qid_t depth_waddr,
	output qm_pkg::cnt_t depth_wdata,
	output logic enq_event,
	output logic deq_event,
	output qm_pkg::port_t event_port
);

	import qm_pkg::*;

	typedef enum logic [2:0] {
		ST_CLEAR,
		ST_IDLE,
		ST_ENQ,
		ST_DEQ,
		ST_DEQ_WR,
		ST_ACK
	} state_t;

	state_t state;
	qid_t clr_cnt;
	qid_t cur_qid;
	qid_t q_raddr;
	buf_t head_rdata;
	buf_t head_wdata;
	buf_t tail_rdata;
	buf_t link_rdata;
	cnt_t depth_rdata;
	pkt_desc_t desc_rdata;
	logic enq_go;
	logic queue_empty;
	logic head_wr;
	logic tail_wr;
	logic link_wr;

	// Queue tables are read as the request is accepted.
	assign q_raddr = (state == ST_IDLE) ? (deq_req ? deq_qid : enq_qid) : cur_qid;

	assign enq_go = (state == ST_ENQ) && (free_count != '0);
	assign queue_empty = (depth_rdata == '0);

	assign head_wr = (enq_go && queue_empty) || (state == ST_DEQ_WR);
	assign head_wdata = (state == ST_DEQ_WR) ? link_rdata : free_head;
	assign tail_wr = enq_go;
	assign link_wr = enq_go && !queue_empty;

	// ------------------------------------------------------------
	// Tables
	// ------------------------------------------------------------
	qm_ram #(.T(buf_t), .DEPTH(NUM_QUEUES)) head_ram_i (
		.clk(clk), .wr(head_wr), .waddr(cur_qid), .wdata(head_wdata),
		.raddr(q_raddr), .rdata(head_rdata)
	);

	qm_ram #(.T(buf_t), .DEPTH(NUM_QUEUES)) tail_ram_i (
		.clk(clk), .wr(tail_wr), .waddr(cur_qid), .wdata(free_head),
		.raddr(q_raddr), .rdata(tail_rdata)
	);

	// Old tail points at the new buffer.
	qm_ram #(.T(buf_t), .DEPTH(NUM_BUFS)) link_ram_i (
		.clk(clk), .wr(link_wr), .waddr(tail_rdata), .wdata(free_head),
		.raddr(head_rdata), .rdata(link_rdata)
	);

	qm_ram #(.T(cnt_t), .DEPTH(NUM_QUEUES)) depth_ram_i (
		.clk(clk), .wr(depth_wr), .waddr(depth_waddr), .wdata(depth_wdata),
		.raddr(q_raddr), .rdata(depth_rdata)
	);

	qm_ram #(.T(pkt_desc_t), .DEPTH(NUM_BUFS)) desc_ram_i (
		.clk(clk), .wr(enq_go), .waddr(free_head), .wdata(enq_desc),
		.raddr(head_rdata), .rdata(desc_rdata)
	);

	// ------------------------------------------------------------
	// Depth, free list and event strobes
	// ------------------------------------------------------------
	assign depth_wr = (state == ST_CLEAR) || enq_go || (state == ST_DEQ_WR);
	assign depth_waddr = (state == ST_CLEAR) ? clr_cnt : cur_qid;

	always_comb begin
		case (state)
			ST_CLEAR: depth_wdata = '0;
			ST_DEQ_WR: depth_wdata = depth_rdata - cnt_t'(1);
			default: depth_wdata = depth_rdata + cnt_t'(1);
		endcase
	end

	assign free_pop = enq_go;
	assign free_push = (state == ST_DEQ_WR);
	assign free_push_buf = head_rdata;

	assign enq_event = enq_go;
	assign deq_event = (state == ST_DEQ_WR);
	assign event_port = deq_event ? desc_rdata.src_port : enq_desc.src_port;

	// ------------------------------------------------------------
	// Sequencer
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_CLEAR;
			clr_cnt <= '0;
			enq_ack <= 1'b0;
			enq_ok <= 1'b0;
			enq_to_empty <= 1'b0;
			deq_ack <= 1'b0;
			deq_ok <= 1'b0;
		end else begin
			case (state)
				ST_CLEAR: begin
					clr_cnt <= clr_cnt + qid_t'(1);
					if (clr_cnt == qid_t'(NUM_QUEUES - 1)) begin
						state <= ST_IDLE;
					end
				end
				ST_IDLE: begin
					// Dequeue wins when both are pending.
					if (free_ready && deq_req) begin
						state <= ST_DEQ;
					end else if (free_ready && enq_req) begin
						state <= ST_ENQ;
					end
				end
				ST_ENQ: begin
					enq_ok <= enq_go;
					enq_to_empty <= enq_go && queue_empty;
					enq_ack <= 1'b1;
					state <= ST_ACK;
				end
				ST_DEQ: begin
					if (queue_empty) begin
						deq_ok <= 1'b0;
						deq_ack <= 1'b1;
						state <= ST_ACK;
					end else begin
						state <= ST_DEQ_WR;
					end
				end
				ST_DEQ_WR: begin
					deq_ok <= 1'b1;
					deq_ack <= 1'b1;
					state <= ST_ACK;
				end
				ST_ACK: begin
					if ((enq_ack && !enq_req) || (deq_ack && !deq_req)) begin
						enq_ack <= 1'b0;
						deq_ack <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_CLEAR;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE) begin
			cur_qid <= q_raddr;
		end
		if (state == ST_DEQ_WR) begin
			deq_desc <= desc_rdata;
		end
	end

endmodule

// ==== design/qm_pkg.sv ====
/*
 * Queue manager shared definitions.
 * Sizes, occupancy levels and the packet descriptor layout.
 */
package qm_pkg;

	// ------------------------------------------------------------
	// Sizes
	// ------------------------------------------------------------
	localparam int NUM_QUEUES = 16;
	localparam int NUM_BUFS = 32;
	localparam int NUM_PORTS = 8;

	typedef logic [$clog2(NUM_QUEUES)-1:0] qid_t;
	typedef logic [$clog2(NUM_BUFS)-1:0] buf_t;
	typedef logic [$clog2(NUM_PORTS)-1:0] port_t;

	// Wide enough to hold a full pool.
	typedef logic [$clog2(NUM_BUFS):0] cnt_t;

	// ------------------------------------------------------------
	// Occupancy levels
	// ------------------------------------------------------------
	// Destinations stay available only above this free level.
	localparam cnt_t MIN_FREE_LEVEL = 4;

	// Sources stay available only below this count.
	localparam cnt_t MAX_PORT_LEVEL = 24;

	// ------------------------------------------------------------
	// Descriptor
	// ------------------------------------------------------------
	typedef struct packed {
		port_t src_port;
		port_t dst_port;
		logic [7:0] tag;
	} pkt_desc_t;

endpackage

// ==== design/qm_port_monitor.sv ====
/*
 * Port monitor.
 * Source occupancy, source and destination availability, alpha
 * register and the availability query for the next stage.
 */
`timescale 1ns/1ps

module qm_port_monitor (
	input  logic clk,
	input  logic rst_n,
	input  logic enq_event,
	input  logic deq_event,
	input  qm_pkg::port_t event_port,
	input  qm_pkg::cnt_t free_count,
	input  logic [qm_pkg::NUM_PORTS-1:0] bp,
	input  logic cfg_wr,
	input  logic [3:0] cfg_alpha,
	input  logic avail_req,
	input  qm_pkg::qid_t avail_qid,
	output logic avail_ack,
	output logic avail_ok,
	output qm_pkg::qid_t mirror_raddr,
	input  qm_pkg::cnt_t mirror_rdata,
	output logic [qm_pkg::NUM_PORTS-1:0] src_avail,
	output logic [qm_pkg::NUM_PORTS-1:0] dst_avail
);

	import qm_pkg::*;

	cnt_t port_cnt [NUM_PORTS];
	cnt_t port_cnt_next [NUM_PORTS];
	logic [3:0] alpha;
	logic [12:0] shl;
	cnt_t threshold;
	logic query_rd;

	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			port_cnt_next[p] = port_cnt[p];
			if (enq_event && event_port == port_t'(p)) begin
				port_cnt_next[p] = port_cnt_next[p] + cnt_t'(1);
			end
			if (deq_event && event_port == port_t'(p)) begin
				port_cnt_next[p] = port_cnt_next[p] - cnt_t'(1);
			end
		end
	end

	// ------------------------------------------------------------
	// Counters, flags and alpha
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				port_cnt[p] <= '0;
			end
			src_avail <= '0;
			dst_avail <= '0;
			alpha <= '0;
		end else begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				port_cnt[p] <= port_cnt_next[p];
				src_avail[p] <= (port_cnt_next[p] < MAX_PORT_LEVEL);
			end
			dst_avail <= ~bp & {NUM_PORTS{free_count > MIN_FREE_LEVEL}};
			if (cfg_wr) begin
				alpha <= cfg_alpha;
			end
		end
	end

	// Left shift saturates at the top of the count range.
	assign shl = {7'b0, free_count} << alpha[2:0];
	assign threshold = alpha[3] ? (free_count >> alpha[2:0]) :
		((|shl[12:6]) ? '1 : shl[5:0]);

	// ------------------------------------------------------------
	// Query
	// ------------------------------------------------------------
	assign mirror_raddr = avail_qid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			query_rd <= 1'b0;
			avail_ack <= 1'b0;
			avail_ok <= 1'b0;
		end else if (avail_ack) begin
			if (!avail_req) begin
				avail_ack <= 1'b0;
			end
		end else if (query_rd) begin
			query_rd <= 1'b0;
			avail_ok <= (mirror_rdata < threshold);
			avail_ack <= 1'b1;
		end else if (avail_req) begin
			query_rd <= 1'b1;
		end
	end

endmodule

// ==== design/qm_ram.sv ====
/*
 * Simple dual port memory.
 * One write port and a registered read port, payload set by type.
 */
`timescale 1ns/1ps

module qm_ram #(
	parameter type T = qm_pkg::buf_t,
	parameter int DEPTH = qm_pkg::NUM_BUFS
) (
	input  logic clk,
	input  logic wr,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  T wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output T rdata
);

	T mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= wdata;
		end
	end

	// Old data is returned on a same-address write.
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== design/qm_top.sv ====
/*
 * Queue manager top level.
 * Link engine, free list, port monitor and the mirrored depth table.
 */
`timescale 1ns/1ps

module qm_top (
	input  logic clk,
	input  logic rst_n,
	input  logic enq_req,
	input  qm_pkg::qid_t enq_qid,
	input  qm_pkg::pkt_desc_t enq_desc,
	output logic enq_ack,
	output logic enq_ok,
	output logic enq_to_empty,
	input  logic deq_req,
	input  qm_pkg::qid_t deq_qid,
	output logic deq_ack,
	output logic deq_ok,
	output qm_pkg::pkt_desc_t deq_desc,
	input  logic [qm_pkg::NUM_PORTS-1:0] bp,
	input  logic cfg_wr,
	input  logic [3:0] cfg_alpha,
	input  logic avail_req,
	input  qm_pkg::qid_t avail_qid,
	output logic avail_ack,
	output logic avail_ok,
	output logic [qm_pkg::NUM_PORTS-1:0] src_avail,
	output logic [qm_pkg::NUM_PORTS-1:0] dst_avail
);

	import qm_pkg::*;

	logic free_ready;
	buf_t free_head;
	cnt_t free_count;
	logic free_pop;
	logic free_push;
	buf_t free_push_buf;
	logic depth_wr;
	qid_t depth_waddr;
	cnt_t depth_wdata;
	logic enq_event;
	logic deq_event;
	port_t event_port;
	qid_t mirror_raddr;
	cnt_t mirror_rdata;

	qm_link_engine engine_i (
		.clk(clk), .rst_n(rst_n),
		.enq_req(enq_req), .enq_qid(enq_qid), .enq_desc(enq_desc),
		.enq_ack(enq_ack), .enq_ok(enq_ok), .enq_to_empty(enq_to_empty),
		.deq_req(deq_req), .deq_qid(deq_qid),
		.deq_ack(deq_ack), .deq_ok(deq_ok), .deq_desc(deq_desc),
		.free_ready(free_ready), .free_head(free_head), .free_count(free_count),
		.free_pop(free_pop), .free_push(free_push), .free_push_buf(free_push_buf),
		.depth_wr(depth_wr), .depth_waddr(depth_waddr), .depth_wdata(depth_wdata),
		.enq_event(enq_event), .deq_event(deq_event), .event_port(event_port)
	);

	qm_free_list free_list_i (
		.clk(clk), .rst_n(rst_n),
		.pop(free_pop), .push(free_push), .push_buf(free_push_buf),
		.head_buf(free_head), .free_count(free_count), .ready(free_ready)
	);

	// Second copy of the depth table, read only by the query.
	qm_ram #(.T(cnt_t), .DEPTH(NUM_QUEUES)) depth_mirror_i (
		.clk(clk), .wr(depth_wr), .waddr(depth_waddr), .wdata(depth_wdata),
		.raddr(mirror_raddr), .rdata(mirror_rdata)
	);

	qm_port_monitor monitor_i (
		.clk(clk), .rst_n(rst_n),
		.enq_event(enq_event), .deq_event(deq_event), .event_port(event_port),
		.free_count(free_count), .bp(bp),
		.cfg_wr(cfg_wr), .cfg_alpha(cfg_alpha),
		.avail_req(avail_req), .avail_qid(avail_qid),
		.avail_ack(avail_ack), .avail_ok(avail_ok),
		.mirror_raddr(mirror_raddr), .mirror_rdata(mirror_rdata),
		.src_avail(src_avail), .dst_avail(dst_avail)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the queue manager testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module qm_tb -f sim.f -o qm_sim
out=$(./obj_dir/qm_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qF -- '*** PASSED ***'; then
	exit 0
fi
exit 1

// ==== sim.f ====
design/qm_pkg.sv
design/qm_ram.sv
design/qm_free_list.sv
design/qm_link_engine.sv
design/qm_port_monitor.sv
design/qm_top.sv
test/qm_tb.sv

// ==== test/qm_tb.sv ====
/*
 * Queue manager testbench.
 * Applies a table of enqueue, dequeue, query and setting rows to the
 * top level and checks every response and both availability vectors.
 */
`timescale 1ns/1ps

module qm_tb;

	import qm_pkg::*;

	typedef enum int {
		OP_ENQ,
		OP_DEQ,
		OP_QUERY,
		OP_BP,
		OP_ALPHA
	} op_kind_t;

	// The tag of a bp or alpha row holds the value to load.
	typedef struct packed {
		op_kind_t kind;
		qid_t qid;
		pkt_desc_t desc;
		int reps;
		logic exp_ok;
		logic exp_empty;
		logic [NUM_PORTS-1:0] exp_src;
		logic [NUM_PORTS-1:0] exp_dst;
	} row_t;

	localparam int ACK_LIMIT = 64;

	logic clk;
	logic rst_n;
	logic enq_req;
	qid_t enq_qid;
	pkt_desc_t enq_desc;
	logic enq_ack;
	logic enq_ok;
	logic enq_to_empty;
	logic deq_req;
	qid_t deq_qid;
	logic deq_ack;
	logic deq_ok;
	pkt_desc_t deq_desc;
	logic [NUM_PORTS-1:0] bp;
	logic cfg_wr;
	logic [3:0] cfg_alpha;
	logic avail_req;
	qid_t avail_qid;
	logic avail_ack;
	logic avail_ok;
	logic [NUM_PORTS-1:0] src_avail;
	logic [NUM_PORTS-1:0] dst_avail;

	row_t rows[$];
	int limit_cycles = 0;

	qm_top qm_top_i (
		.clk(clk), .rst_n(rst_n),
		.enq_req(enq_req), .enq_qid(enq_qid), .enq_desc(enq_desc),
		.enq_ack(enq_ack), .enq_ok(enq_ok), .enq_to_empty(enq_to_empty),
		.deq_req(deq_req), .deq_qid(deq_qid),
		.deq_ack(deq_ack), .deq_ok(deq_ok), .deq_desc(deq_desc),
		.bp(bp), .cfg_wr(cfg_wr), .cfg_alpha(cfg_alpha),
		.avail_req(avail_req), .avail_qid(avail_qid),
		.avail_ack(avail_ack), .avail_ok(avail_ok),
		.src_avail(src_avail), .dst_avail(dst_avail)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------
	// Checks and handshakes
	// ------------------------------------------------------------
	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic ack_of(input op_kind_t kind);
		case (kind)
			OP_ENQ: return enq_ack;
			OP_DEQ: return deq_ack;
			default: return avail_ack;
		endcase
	endfunction

	task automatic wait_ack(input op_kind_t kind, input logic level);
		int n;
		n = 0;
		while (ack_of(kind) !== level && n < ACK_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (ack_of(kind) !== level) begin
			$display("handshake timeout: %s ack did not go to %0d", kind.name(), level);
			$display("*** FAILED ***");
			$fatal(1, "handshake timeout");
		end
	endtask

	task automatic enqueue(input qid_t q, input pkt_desc_t d, input logic ok, input logic empty);
		enq_qid = q;
		enq_desc = d;
		enq_req = 1'b1;
		wait_ack(OP_ENQ, 1'b1);
		check("enq_ok", 32'(enq_ok), 32'(ok));
		check("enq_to_empty", 32'(enq_to_empty), 32'(empty));
		enq_req = 1'b0;
		wait_ack(OP_ENQ, 1'b0);
	endtask

	task automatic dequeue(input qid_t q, input pkt_desc_t d, input logic ok);
		deq_qid = q;
		deq_req = 1'b1;
		wait_ack(OP_DEQ, 1'b1);
		check("deq_ok", 32'(deq_ok), 32'(ok));
		if (ok) begin
			check("deq_desc", 32'(deq_desc), 32'(d));
		end
		deq_req = 1'b0;
		wait_ack(OP_DEQ, 1'b0);
	endtask

	task automatic query_avail(input qid_t q, input logic ok);
		avail_qid = q;
		avail_req = 1'b1;
		wait_ack(OP_QUERY, 1'b1);
		check("avail_ok", 32'(avail_ok), 32'(ok));
		avail_req = 1'b0;
		wait_ack(OP_QUERY, 1'b0);
	endtask

	task automatic set_alpha(input logic [3:0] value);
		cfg_alpha = value;
		cfg_wr = 1'b1;
		@(posedge clk);
		#1;
		cfg_wr = 1'b0;
	endtask

	// Tags step by one on every repeat of a row.
	task automatic run_row(input row_t r);
		pkt_desc_t d;
		for (int i = 0; i < r.reps; i++) begin
			d = r.desc;
			d.tag = r.desc.tag + 8'(i);
			case (r.kind)
				OP_ENQ: enqueue(r.qid, d, r.exp_ok, r.exp_empty && i == 0);
				OP_DEQ: dequeue(r.qid, d, r.exp_ok);
				OP_QUERY: query_avail(r.qid, r.exp_ok);
				OP_BP: bp = r.desc.tag;
				default: set_alpha(r.desc.tag[3:0]);
			endcase
		end
		repeat (2) @(posedge clk);
		#1;
		check("src_avail", 32'(src_avail), 32'(r.exp_src));
		check("dst_avail", 32'(dst_avail), 32'(r.exp_dst));
	endtask

	// ------------------------------------------------------------
	// Operation table
	// ------------------------------------------------------------
	task automatic add_row(input op_kind_t kind, input int qid, input int src, input int dst,
		input int tag, input int reps, input logic ok, input logic empty,
		input logic [NUM_PORTS-1:0] src_exp, input logic [NUM_PORTS-1:0] dst_exp);
		row_t r;
		r.kind = kind;
		r.qid = qid_t'(qid);
		r.desc.src_port = port_t'(src);
		r.desc.dst_port = port_t'(dst);
		r.desc.tag = 8'(tag);
		r.reps = reps;
		r.exp_ok = ok;
		r.exp_empty = empty;
		r.exp_src = src_exp;
		r.exp_dst = dst_exp;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// Order, enqueue-to-empty and queue separation.
		add_row(OP_ENQ, 1, 0, 1, 'h10, 3, 1'b1, 1'b1, 8'hff, 8'hff);
		add_row(OP_ENQ, 2, 1, 2, 'h20, 2, 1'b1, 1'b1, 8'hff, 8'hff);
		add_row(OP_ENQ, 1, 0, 1, 'h13, 1, 1'b1, 1'b0, 8'hff, 8'hff);
		add_row(OP_DEQ, 1, 0, 1, 'h10, 4, 1'b1, 1'b0, 8'hff, 8'hff);
		add_row(OP_DEQ, 2, 1, 2, 'h20, 2, 1'b1, 1'b0, 8'hff, 8'hff);
		// Empty dequeue, then the queue still works.
		add_row(OP_DEQ, 1, 0, 0, 'h00, 1, 1'b0, 1'b0, 8'hff, 8'hff);
		add_row(OP_ENQ, 1, 7, 0, 'h30, 1, 1'b1, 1'b1, 8'hff, 8'hff);
		add_row(OP_DEQ, 1, 7, 0, 'h30, 1, 1'b1, 1'b0, 8'hff, 8'hff);
		// Exhaustion. Free count 5 keeps destinations, 4 and below clears them.
		add_row(OP_ENQ, 4, 3, 4, 'h40, 20, 1'b1, 1'b1, 8'hff, 8'hff);
		add_row(OP_ENQ, 5, 4, 5, 'h60, 7, 1'b1, 1'b1, 8'hff, 8'hff);
		add_row(OP_ENQ, 5, 4, 5, 'h67, 1, 1'b1, 1'b0, 8'hff, 8'h00);
		add_row(OP_ENQ, 5, 4, 5, 'h68, 4, 1'b1, 1'b0, 8'hff, 8'h00);
		add_row(OP_ENQ, 6, 5, 6, 'h70, 1, 1'b0, 1'b0, 8'hff, 8'h00);
		add_row(OP_DEQ, 4, 3, 4, 'h40, 1, 1'b1, 1'b0, 8'hff, 8'h00);
		add_row(OP_ENQ, 6, 5, 6, 'h70, 1, 1'b1, 1'b1, 8'hff, 8'h00);
		add_row(OP_DEQ, 6, 5, 6, 'h70, 1, 1'b1, 1'b0, 8'hff, 8'h00);
		add_row(OP_DEQ, 4, 3, 4, 'h41, 4, 1'b1, 1'b0, 8'hff, 8'hff);
		add_row(OP_DEQ, 4, 3, 4, 'h45, 15, 1'b1, 1'b0, 8'hff, 8'hff);
		add_row(OP_DEQ, 5, 4, 5, 'h60, 12, 1'b1, 1'b0, 8'hff, 8'hff);
		// Source port 2 reaches its limit at 24 held packets.
		add_row(OP_ENQ, 7, 2, 3, 'h80, 24, 1'b1, 1'b1, 8'hfb, 8'hff);
		add_row(OP_DEQ, 7, 2, 3, 'h80, 1, 1'b1, 1'b0, 8'hff, 8'hff);
		add_row(OP_DEQ, 7, 2, 3, 'h81, 23, 1'b1, 1'b0, 8'hff, 8'hff);
		// Back-pressure on port 5.
		add_row(OP_BP, 0, 0, 0, 'h20, 1, 1'b0, 1'b0, 8'hff, 8'hdf);
		add_row(OP_BP, 0, 0, 0, 'h00, 1, 1'b0, 1'b0, 8'hff, 8'hff);
		// Six packets in queue 3 leave 26 buffers free.
		add_row(OP_ENQ, 3, 6, 7, 'h90, 6, 1'b1, 1'b1, 8'hff, 8'hff);
		// Threshold 26 >> 1 = 13.
		add_row(OP_ALPHA, 0, 0, 0, 'h09, 1, 1'b0, 1'b0, 8'hff, 8'hff);
		add_row(OP_QUERY, 3, 0, 0, 'h00, 1, 1'b1, 1'b0, 8'hff, 8'hff);
		// Threshold 26 >> 3 = 3.
		add_row(OP_ALPHA, 0, 0, 0, 'h0b, 1, 1'b0, 1'b0, 8'hff, 8'hff);
		add_row(OP_QUERY, 3, 0, 0, 'h00, 1, 1'b0, 1'b0, 8'hff, 8'hff);
		// Threshold 26 << 0 = 26.
		add_row(OP_ALPHA, 0, 0, 0, 'h00, 1, 1'b0, 1'b0, 8'hff, 8'hff);
		add_row(OP_QUERY, 3, 0, 0, 'h00, 1, 1'b1, 1'b0, 8'hff, 8'hff);
		add_row(OP_DEQ, 3, 6, 7, 'h90, 6, 1'b1, 1'b0, 8'hff, 8'hff);
	endtask

	// ------------------------------------------------------------
	// Main sequence and watchdog
	// ------------------------------------------------------------
	initial begin
		rst_n = 1'b0;
		enq_req = 1'b0;
		enq_qid = '0;
		enq_desc = '0;
		deq_req = 1'b0;
		deq_qid = '0;
		bp = '0;
		cfg_wr = 1'b0;
		cfg_alpha = '0;
		avail_req = 1'b0;
		avail_qid = '0;
		build_table();
		limit_cycles = 200 + 100 * rows.size();
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		foreach (rows[i]) begin
			run_row(rows[i]);
		end
		$display("*** PASSED ***");
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog: the run did not finish within %0d cycles", limit_cycles);
		$display("*** FAILED ***");
		$fatal(1, "watchdog timeout");
	end

endmodule
